/* matchedFilter.f */
src/mfPkg.sv
src/delayLine.sv
src/hilbertTransform.sv
src/coeffRegs.sv
src/complexFir.sv
src/magnitudeEstimator.sv
src/matchedFilter.sv
tests/tbClock.sv
tests/matchedFilter_chk.sv
tests/matchedFilterTb.sv

/* run.sh */
#!/bin/sh
# Compiles the matched filter testbench with Verilator, runs it and checks the result.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module matchedFilterTb \
	-f matchedFilter.f -o matchedFilterSim || { echo "Build failed"; exit 1; }
out=$(./obj_dir/matchedFilterSim +verilator+error+limit+100 2>&1)
echo "$out"
echo "$out" | grep -q "Everything OK" && echo "PASS" || { echo "FAIL"; exit 1; }

/* tests/matchedFilterTb.sv */
`timescale 1ns/1ps
`default_nettype none

module matchedFilterTb
	import mfPkg::*;
();

	localparam int NUM_TAPS = 8;
	localparam int LATENCY = 3;
	localparam int WAIT_LIMIT = 100;
	localparam int HILBERT_Q7 [7] = '{-27, 0, -81, 0, 81, 0, 27};
	localparam longint MAG_MAX = 64'h0000_0000_FFFF_FFFF;
	localparam logic [7:0] UNMAPPED [4] = '{8'd1, 8'd5, 8'd24, 8'd255};

	logic clock;
	logic rst;
	sample_t sample;
	logic sampleValid;
	mag_t mag;
	logic magValid;
	logic wbCyc;
	logic wbStb;
	logic wbWe;
	logic [7:0] wbAdr;
	logic [31:0] wbWdata;
	logic [31:0] wbRdata;
	logic wbAck;

	int cycle = 0;
	logic modelRun = 1'b0;
	sample_t sampleHist [7];
	analytic_t analyticHist [NUM_TAPS];
	coeff_t modelTaps [NUM_TAPS];
	mag_t expMags [$];
	int expCycles [$];

	tbClock #(.PERIOD(20)) i_tbClock (.clock(clock));

	matchedFilter #(
		.NUM_TAPS (NUM_TAPS)
	) i_matchedFilter (
		.clock       (clock),
		.rst         (rst),
		.sample      (sample),
		.sampleValid (sampleValid),
		.mag         (mag),
		.magValid    (magValid),
		.wbCyc       (wbCyc),
		.wbStb       (wbStb),
		.wbWe        (wbWe),
		.wbAdr       (wbAdr),
		.wbWdata     (wbWdata),
		.wbRdata     (wbRdata),
		.wbAck       (wbAck)
	);

	always @(posedge clock) cycle <= cycle + 1;

	task automatic abortRun();
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic checkMag(input mag_t got, input mag_t exp);
		if (got !== exp) begin
			$display("ERROR at %0d ns: magnitude %0d, expected %0d", $time, got, exp);
			abortRun();
		end
	endtask

	task automatic checkReg(input logic [31:0] got, input logic [31:0] exp, input logic [7:0] adr);
		if (got !== exp) begin
			$display("ERROR at %0d ns: register %0d read %h, expected %h", $time, adr, got, exp);
			abortRun();
		end
	endtask

	function automatic analytic_t hilbertModel();
		longint acc;
		analytic_t a;
		acc = 0;
		for (int i = 0; i < 7; i++) begin
			acc += HILBERT_Q7[i] * longint'(sampleHist[i]);
		end
		a.re = sampleHist[3]; // centre tap, sign-extended.
		a.im = ANALYTIC_W'(acc >>> 7);
		return a;
	endfunction

	function automatic mag_t matchModel();
		longint re;
		longint im;
		longint absRe;
		longint absIm;
		longint est;
		re = 0;
		im = 0;
		for (int k = 0; k < NUM_TAPS; k++) begin
			re += longint'(analyticHist[k].re) * modelTaps[k].re;
			re -= longint'(analyticHist[k].im) * modelTaps[k].im;
			im += longint'(analyticHist[k].re) * modelTaps[k].im;
			im += longint'(analyticHist[k].im) * modelTaps[k].re;
		end
		re = $signed(re[31:0]); // accumulator parts are 32 bits wide.
		im = $signed(im[31:0]);
		absRe = (re < 0) ? -re : re;
		absIm = (im < 0) ? -im : im;
		est = (absRe > absIm) ? absRe + (absIm >> 1) : absIm + (absRe >> 1);
		if (est > MAG_MAX) begin
			est = MAG_MAX;
		end
		return mag_t'(est);
	endfunction

	task automatic modelAccept(input sample_t s);
		for (int i = 6; i > 0; i--) begin
			sampleHist[i] = sampleHist[i-1];
		end
		sampleHist[0] = s;
		for (int k = NUM_TAPS - 1; k > 0; k--) begin
			analyticHist[k] = analyticHist[k-1];
		end
		analyticHist[0] = hilbertModel();
		expMags.push_back(matchModel());
	endtask

	task automatic modelClear();
		for (int i = 0; i < 7; i++) begin
			sampleHist[i] = '0;
		end
		for (int k = 0; k < NUM_TAPS; k++) begin
			analyticHist[k] = '0;
		end
	endtask

	task automatic waitAck();
		int waited;
		waited = 0;
		do begin
			@(negedge clock);
			waited++;
			if (waited > WAIT_LIMIT) begin
				$display("Timed out waiting for wbAck.");
				abortRun();
			end
		end while (!wbAck);
	endtask

	task automatic wbWrite(input logic [7:0] adr, input logic [31:0] data);
		@(negedge clock);
		sampleValid = 1'b0;
		wbCyc = 1'b1;
		wbStb = 1'b1;
		wbWe = 1'b1;
		wbAdr = adr;
		wbWdata = data;
		waitAck();
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe = 1'b0;
	endtask

	task automatic wbRead(input logic [7:0] adr, output logic [31:0] data);
		@(negedge clock);
		sampleValid = 1'b0;
		wbCyc = 1'b1;
		wbStb = 1'b1;
		wbWe = 1'b0;
		wbAdr = adr;
		waitAck();
		data = wbRdata; // read data comes with the ack.
		wbCyc = 1'b0;
		wbStb = 1'b0;
	endtask

	task automatic writeTap(input int k, input logic [31:0] data);
		wbWrite(REG_COEFF_BASE + 8'(k), data);
		modelTaps[k].re = data[11:0];
		modelTaps[k].im = data[27:16];
	endtask

	task automatic setRun(input logic on);
		wbWrite(REG_CTRL, {31'b0, on});
		modelRun = on;
		if (!on) begin
			modelClear(); // the DUT wipes its histories while stopped.
		end
	endtask

	task automatic offerSample(input sample_t s, input logic valid);
		@(negedge clock);
		sample = s;
		sampleValid = valid;
		if (valid && modelRun) begin
			modelAccept(s);
			expCycles.push_back(cycle + 1 + LATENCY); // accepted at the next rising edge.
		end
	endtask

	task automatic drainOutputs();
		int waited;
		waited = 0;
		@(negedge clock);
		sampleValid = 1'b0;
		while (expMags.size() != 0) begin
			@(negedge clock);
			waited++;
			if (waited > WAIT_LIMIT) begin
				$display("Timed out waiting for the pending outputs.");
				abortRun();
			end
		end
	endtask

	function automatic logic [11:0] extremeValue();
		return ($urandom() % 2) ? 12'h7FF : 12'h800;
	endfunction

	always @(negedge clock) begin
		if (i_matchedFilter.i_matchedFilterChk.failCount != 0) begin
			$display("A bound assertion on the DUT failed.");
			abortRun();
		end else if (!rst && magValid) begin
			if (expMags.size() == 0) begin
				$display("magValid was high with no accepted sample pending.");
				abortRun();
			end else if (expCycles[0] != cycle) begin
				$display("ERROR at %0d ns: output in cycle %0d, expected in cycle %0d",
					$time, cycle, expCycles[0]);
				abortRun();
			end else begin
				checkMag(mag, expMags.pop_front());
				void'(expCycles.pop_front());
			end
		end else if (expCycles.size() != 0 && expCycles[0] <= cycle) begin
			$display("An expected magnitude output never appeared.");
			abortRun();
		end
	end

	initial begin
		logic [31:0] data;
		logic [31:0] got;
		void'($urandom(48));
		rst = 1'b1;
		sample = '0;
		sampleValid = 1'b0;
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe = 1'b0;
		wbAdr = '0;
		wbWdata = '0;
		modelClear();
		for (int k = 0; k < NUM_TAPS; k++) begin
			modelTaps[k] = '0;
		end
		repeat (4) @(negedge clock);
		rst = 1'b0;

		@(negedge clock);
		if (magValid !== 1'b0 || wbAck !== 1'b0) begin
			$display("magValid or wbAck is not low after reset.");
			abortRun();
		end
		wbRead(REG_CTRL, got);
		checkReg(got, 32'h0, REG_CTRL);
		for (int k = 0; k < NUM_TAPS; k++) begin
			wbRead(REG_COEFF_BASE + 8'(k), got);
			checkReg(got, 32'h0, REG_COEFF_BASE + 8'(k));
		end

		for (int k = 0; k < NUM_TAPS; k++) begin
			writeTap(k, $urandom());
		end
		wbWrite(8'd5, $urandom()); // lands on no register.
		for (int k = 0; k < NUM_TAPS; k++) begin
			wbRead(REG_COEFF_BASE + 8'(k), got);
			checkReg(got, {4'h0, modelTaps[k].im, 4'h0, modelTaps[k].re}, REG_COEFF_BASE + 8'(k));
		end
		for (int i = 0; i < 4; i++) begin
			wbRead(UNMAPPED[i], got);
			checkReg(got, 32'h0, UNMAPPED[i]);
		end
		wbWrite(REG_CTRL, 32'hFFFF_FFFE);
		wbRead(REG_CTRL, got);
		checkReg(got, 32'h0, REG_CTRL);
		setRun(1'b1);
		wbRead(REG_CTRL, got);
		checkReg(got, 32'h1, REG_CTRL);

		repeat (200) offerSample(sample_t'($urandom()), ($urandom() % 4) != 0);
		drainOutputs();

		setRun(1'b0);
		repeat (20) offerSample(sample_t'($urandom()), 1'b1);
		repeat (8) offerSample('0, 1'b0);
		setRun(1'b1);
		repeat (60) offerSample(sample_t'($urandom()), ($urandom() % 3) != 0);
		drainOutputs();

		setRun(1'b0);
		for (int k = 0; k < NUM_TAPS; k++) begin
			writeTap(k, {4'h0, 12'h800, 4'h0, 12'h800});
		end
		setRun(1'b1);
		repeat (16) offerSample(sample_t'(12'h800), 1'b1);
		drainOutputs();
		setRun(1'b0);
		for (int k = 0; k < NUM_TAPS; k++) begin
			data = {4'h0, extremeValue(), 4'h0, extremeValue()};
			writeTap(k, data);
		end
		setRun(1'b1);
		repeat (60) offerSample(sample_t'(extremeValue()), 1'b1);
		drainOutputs();

		if (i_matchedFilter.i_matchedFilterChk.failCount != 0) begin
			$display("A bound assertion on the DUT failed.");
			abortRun();
		end else begin
			$display("Everything OK");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* tests/matchedFilter_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module matchedFilter_chk (
	input wire logic clock,
	input wire logic rst,
	input wire logic wbCyc,
	input wire logic wbStb,
	input wire logic wbAck,
	input wire logic accept,
	input wire logic analyticValid,
	input wire logic resultValid,
	input wire logic magValid
);

	int failCount = 0; // read by the testbench after each cycle.

	ackAfterStrobe: assert property (@(posedge clock) disable iff (rst)
		wbAck |-> $past(wbCyc && wbStb))
		else begin
			failCount++;
			$error("wbAck rose without a preceding strobe.");
		end

	ackSingleCycle: assert property (@(posedge clock) disable iff (rst)
		wbAck |=> !wbAck)
		else begin
			failCount++;
			$error("wbAck stayed high for two cycles.");
		end

	// accept is sampled on the edge that takes the sample.
	// magValid registers three edges later and is seen on the fourth.
	fixedLatency: assert property (@(posedge clock) disable iff (rst)
		magValid == $past(accept, 4))
		else begin
			failCount++;
			$error("magValid does not follow accept by 3 cycles.");
		end

	validsInReset: assert property (@(posedge clock)
		rst |=> (!magValid && !analyticValid && !resultValid && !wbAck))
		else begin
			failCount++;
			$error("A valid flag or wbAck is high in reset.");
		end

endmodule

bind matchedFilter matchedFilter_chk i_matchedFilterChk (
	.clock         (clock),
	.rst           (rst),
	.wbCyc         (wbCyc),
	.wbStb         (wbStb),
	.wbAck         (wbAck),
	.accept        (accept),
	.analyticValid (analyticValid),
	.resultValid   (resultValid),
	.magValid      (magValid)
);

`default_nettype wire

/* tests/tbClock.sv */
`timescale 1ns/1ps
`default_nettype none

module tbClock #(
	parameter int PERIOD = 20
) (
	output logic clock
);

	initial begin
		clock = 1'b0;
		forever begin
			#(PERIOD / 2) clock = ~clock; // half period in ns.
		end
	end

endmodule

`default_nettype wire

/* src/matchedFilter.sv */
`timescale 1ns/1ps
`default_nettype none

module matchedFilter
	import mfPkg::*;
#(
	parameter int NUM_TAPS = 8
) (
	input wire logic clock,
	input wire logic rst,

	input wire sample_t sample,
	input wire logic sampleValid,

	output mag_t mag,
	output logic magValid,

	input wire logic wbCyc,
	input wire logic wbStb,
	input wire logic wbWe,
	input wire logic [WB_ADR_W-1:0] wbAdr,
	input wire logic [WB_DATA_W-1:0] wbWdata,
	output logic [WB_DATA_W-1:0] wbRdata,
	output logic wbAck
);

	logic run;
	logic accept;
	logic flush;
	coeff_t taps [NUM_TAPS];
	analytic_t analytic;
	logic analyticValid;
	acc_t result;
	logic resultValid;

	assign accept = sampleValid & run; // samples offered while stopped are dropped.
	assign flush = ~run; // stopping wipes both histories.

	coeffRegs #(
		.NUM_TAPS (NUM_TAPS)
	) i_coeffRegs (
		.clock   (clock),
		.rst     (rst),
		.wbCyc   (wbCyc),
		.wbStb   (wbStb),
		.wbWe    (wbWe),
		.wbAdr   (wbAdr),
		.wbWdata (wbWdata),
		.wbRdata (wbRdata),
		.wbAck   (wbAck),
		.run     (run),
		.taps    (taps)
	);

	hilbertTransform i_hilbertTransform (
		.clock         (clock),
		.rst           (rst),
		.accept        (accept),
		.flush         (flush),
		.sample        (sample),
		.analytic      (analytic),
		.analyticValid (analyticValid)
	);

	complexFir #(
		.NUM_TAPS (NUM_TAPS)
	) i_complexFir (
		.clock         (clock),
		.rst           (rst),
		.flush         (flush),
		.analytic      (analytic),
		.analyticValid (analyticValid),
		.taps          (taps),
		.result        (result),
		.resultValid   (resultValid)
	);

	magnitudeEstimator i_magnitudeEstimator (
		.clock       (clock),
		.rst         (rst),
		.result      (result),
		.resultValid (resultValid),
		.mag         (mag),
		.magValid    (magValid)
	);

endmodule

`default_nettype wire

/* src/magnitudeEstimator.sv */
`timescale 1ns/1ps
`default_nettype none

module magnitudeEstimator
	import mfPkg::*;
(
	input wire logic clock,
	input wire logic rst,
	input wire acc_t result,
	input wire logic resultValid,
	output mag_t mag,
	output logic magValid
);

	mag_t absRe;
	mag_t absIm;
	mag_t larger;
	mag_t smaller;
	logic [MAG_W:0] estimate; // one spare bit to catch the overflow.

	// the most negative value still fits, since mag_t is unsigned.
	assign absRe = result.re[ACC_W-1] ? mag_t'(-result.re) : mag_t'(result.re);
	assign absIm = result.im[ACC_W-1] ? mag_t'(-result.im) : mag_t'(result.im);

	assign larger = (absRe > absIm) ? absRe : absIm;
	assign smaller = (absRe > absIm) ? absIm : absRe;
	assign estimate = {1'b0, larger} + {2'b00, smaller[MAG_W-1:1]};

	always_ff @(posedge clock) begin
		if (rst) begin
			magValid <= 1'b0;
		end else begin
			magValid <= resultValid;
		end
	end

	always_ff @(posedge clock) begin
		if (resultValid) begin
			mag <= estimate[MAG_W] ? '1 : estimate[MAG_W-1:0]; // saturate at full scale.
		end
	end

endmodule

`default_nettype wire

/* src/complexFir.sv */
`timescale 1ns/1ps
`default_nettype none

module complexFir
	import mfPkg::*;
#(
	parameter int NUM_TAPS = 8
) (
	input wire logic clock,
	input wire logic rst,
	input wire logic flush,
	input wire analytic_t analytic,
	input wire logic analyticValid,
	input wire coeff_t taps [NUM_TAPS],
	output acc_t result,
	output logic resultValid
);

	// the newest history element is the input itself, so one fewer is stored.
	localparam int STORED = NUM_TAPS - 1;
	localparam int PROD_W = ANALYTIC_W + COEFF_W;

	analytic_t stored [STORED];
	analytic_t history [NUM_TAPS];
	acc_t sum;
	logic signed [PROD_W-1:0] prodRR;
	logic signed [PROD_W-1:0] prodII;
	logic signed [PROD_W-1:0] prodRI;
	logic signed [PROD_W-1:0] prodIR;

	delayLine #(
		.elem_t (analytic_t),
		.DEPTH  (STORED)
	) i_delayLine (
		.clock (clock),
		.rst   (rst),
		.shift (analyticValid),
		.clear (flush),
		.din   (analytic),
		.taps  (stored)
	);

	always_comb begin
		history[0] = analytic;
		for (int k = 1; k < NUM_TAPS; k++) begin
			history[k] = stored[k-1];
		end
	end

	// complex multiply-accumulate over the whole history.
	always_comb begin
		sum = '0;
		for (int k = 0; k < NUM_TAPS; k++) begin
			prodRR = history[k].re * taps[k].re;
			prodII = history[k].im * taps[k].im;
			prodRI = history[k].re * taps[k].im;
			prodIR = history[k].im * taps[k].re;
			sum.re = sum.re + ACC_W'(prodRR) - ACC_W'(prodII);
			sum.im = sum.im + ACC_W'(prodRI) + ACC_W'(prodIR);
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			resultValid <= 1'b0;
		end else begin
			resultValid <= analyticValid;
		end
	end

	always_ff @(posedge clock) begin
		if (analyticValid) begin
			result <= sum;
		end
	end

endmodule

`default_nettype wire

/* src/coeffRegs.sv */
`timescale 1ns/1ps
`default_nettype none

module coeffRegs
	import mfPkg::*;
#(
	parameter int NUM_TAPS = 8
) (
	input wire logic clock,
	input wire logic rst,
	input wire logic wbCyc,
	input wire logic wbStb,
	input wire logic wbWe,
	input wire logic [WB_ADR_W-1:0] wbAdr,
	input wire logic [WB_DATA_W-1:0] wbWdata,
	output logic [WB_DATA_W-1:0] wbRdata,
	output logic wbAck,
	output logic run,
	output coeff_t taps [NUM_TAPS]
);

	logic request;
	logic ctrlHit;
	logic [NUM_TAPS-1:0] tapHit;
	logic [WB_DATA_W-1:0] readData;

	// a new cycle is served once; the master drops wbStb after the ack.
	assign request = wbCyc & wbStb & ~wbAck;
	assign ctrlHit = (wbAdr == REG_CTRL);

	always_comb begin
		readData = '0; // unmapped addresses read as zero.
		if (ctrlHit) begin
			readData[0] = run;
		end
		for (int k = 0; k < NUM_TAPS; k++) begin
			tapHit[k] = (wbAdr == REG_COEFF_BASE + WB_ADR_W'(k));
			if (tapHit[k]) begin
				readData[COEFF_W-1:0] = taps[k].re;
				readData[TAP_IM_LSB +: COEFF_W] = taps[k].im;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			wbAck <= 1'b0;
			run <= 1'b0;
			for (int k = 0; k < NUM_TAPS; k++) begin
				taps[k] <= '0;
			end
		end else begin
			wbAck <= request;
			if (request && wbWe) begin
				if (ctrlHit) begin
					run <= wbWdata[0];
				end
				for (int k = 0; k < NUM_TAPS; k++) begin
					if (tapHit[k]) begin
						taps[k].re <= wbWdata[COEFF_W-1:0];
						taps[k].im <= wbWdata[TAP_IM_LSB +: COEFF_W];
					end
				end
			end
		end
	end

	// read data is presented together with the ack.
	always_ff @(posedge clock) begin
		if (request) begin
			wbRdata <= readData;
		end
	end

endmodule

`default_nettype wire

/* src/hilbertTransform.sv */
`timescale 1ns/1ps
`default_nettype none

module hilbertTransform
	import mfPkg::*;
(
	input wire logic clock,
	input wire logic rst,
	input wire logic accept,
	input wire logic flush,
	input wire sample_t sample,
	output analytic_t analytic,
	output logic analyticValid
);

	localparam int CENTRE = HT_TAPS / 2;

	sample_t history [HT_TAPS];
	logic acceptD;
	int imSum;

	delayLine #(
		.elem_t (sample_t),
		.DEPTH  (HT_TAPS)
	) i_delayLine (
		.clock (clock),
		.rst   (rst),
		.shift (accept),
		.clear (flush),
		.din   (sample),
		.taps  (history)
	);

	// quadrature part of the analytic signal, still in Q7.
	always_comb begin
		imSum = 0;
		for (int i = 0; i < HT_TAPS; i++) begin
			imSum = imSum + HT_COEF[i] * int'(history[i]);
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			acceptD <= 1'b0;
			analyticValid <= 1'b0;
		end else begin
			acceptD <= accept; // delay line has shifted by the time this is high.
			analyticValid <= acceptD;
		end
	end

	always_ff @(posedge clock) begin
		if (acceptD) begin
			analytic.re <= ANALYTIC_W'(history[CENTRE]); // centre tap matches the filter delay.
			analytic.im <= ANALYTIC_W'(imSum >>> HT_SHIFT);
		end
	end

endmodule

`default_nettype wire

/* src/delayLine.sv */
`timescale 1ns/1ps
`default_nettype none

module delayLine #(
	parameter type elem_t = logic [7:0],
	parameter int DEPTH = 4
) (
	input wire logic clock,
	input wire logic rst,
	input wire logic shift,
	input wire logic clear,
	input wire elem_t din,
	output elem_t taps [DEPTH]
);

	always_ff @(posedge clock) begin
		if (rst || clear) begin
			for (int i = 0; i < DEPTH; i++) begin
				taps[i] <= '0;
			end
		end else if (shift) begin
			taps[0] <= din; // newest element goes in front.
			for (int i = 1; i < DEPTH; i++) begin
				taps[i] <= taps[i-1];
			end
		end
	end

endmodule

`default_nettype wire

/* src/mfPkg.sv */
`default_nettype none

package mfPkg;

	localparam int SAMPLE_W = 12;
	localparam int ANALYTIC_W = 14;
	localparam int COEFF_W = 12;
	localparam int ACC_W = 32;
	localparam int MAG_W = 32;

	localparam int WB_ADR_W = 8;
	localparam int WB_DATA_W = 32;

	typedef logic signed [SAMPLE_W-1:0] sample_t;

	typedef struct packed {
		logic signed [ANALYTIC_W-1:0] re;
		logic signed [ANALYTIC_W-1:0] im;
	} analytic_t;

	typedef struct packed {
		logic signed [COEFF_W-1:0] re;
		logic signed [COEFF_W-1:0] im;
	} coeff_t;

	typedef struct packed {
		logic signed [ACC_W-1:0] re;
		logic signed [ACC_W-1:0] im;
	} acc_t;

	typedef logic [MAG_W-1:0] mag_t;

	// Entry i multiplies delay line tap i (tap 0 is the newest sample), i.e. offsets -3 to +3.
	localparam int HT_TAPS = 7;
	localparam int HT_COEF [HT_TAPS] = '{-27, 0, -81, 0, 81, 0, 27};
	localparam int HT_SHIFT = 7; // coefficients are in Q7.

	localparam logic [WB_ADR_W-1:0] REG_CTRL = 8'd0;
	localparam logic [WB_ADR_W-1:0] REG_COEFF_BASE = 8'd16;
	localparam int TAP_IM_LSB = 16; // imaginary field of a tap register starts here.

endpackage

`default_nettype wire
